// File: rtl/div_types_pkg.sv
// Divider request and response types
`default_nettype none

package div_types_pkg;

    // operand and result width
    localparam int DATA_W = 32;

    // shift and round counts, wide enough to hold 32
    localparam int CNT_W = 6;

    // result select carried with each request
    typedef enum logic {
        OP_QUOT = 1'b0,
        OP_REM  = 1'b1
    } div_op_e;

    // request side of the handshake, 66 bits
    typedef struct packed {
        logic [DATA_W-1:0] dividend;
        logic [DATA_W-1:0] divisor;
        div_op_e           op;
        logic              is_signed;
    } div_req_t;

    // response side, 33 bits
    typedef struct packed {
        logic [DATA_W-1:0] result;
        logic              div_zero;
    } div_rsp_t;

    // unsigned magnitudes sent to the iterative core
    typedef struct packed {
        logic [DATA_W-1:0] dividend;
        logic [DATA_W-1:0] divisor;
    } core_cmd_t;

    // unsigned core result, valid with done
    typedef struct packed {
        logic [DATA_W-1:0] quotient;
        logic [DATA_W-1:0] remainder;
        logic              div_zero;
    } core_res_t;

endpackage

`default_nettype wire

// File: rtl/srt_state_pkg.sv
// Divider FSM states and SRT digits
`default_nettype none

package srt_state_pkg;

    // iterative core
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        NORMALIZE = 2'd1,
        ITERATE   = 2'd2,
        CORRECT   = 2'd3
    } core_state_e;

    // handshake control
    typedef enum logic [1:0] {
        WAIT_REQ = 2'd0,
        RUN      = 2'd1,
        HOLD_ACK = 2'd2
    } ctrl_state_e;

    // radix-2 quotient digit: +1, 0, -1
    typedef enum logic [1:0] {
        DIGIT_POS  = 2'd0,
        DIGIT_ZERO = 2'd1,
        DIGIT_NEG  = 2'd2
    } srt_digit_e;

endpackage

`default_nettype wire

// File: rtl/leading_zero_counter.sv
// Leading-zero counter
`default_nettype none

module leading_zero_counter (
    input  wire logic [div_types_pkg::DATA_W-1:0] data,
    output logic [div_types_pkg::CNT_W-1:0]       count
);

    // window kept at each split level
    logic [15:0] half;
    logic [7:0]  quarter;
    logic [3:0]  eighth;
    logic [1:0]  pair;

    // set when the upper part of a window is all zero
    logic z16;
    logic z8;
    logic z4;
    logic z2;
    logic z1;
    logic all_zero;

    // halves
    assign z16  = ~|data[31:16];
    assign half = z16 ? data[15:0] : data[31:16];

    // quarters
    assign z8      = ~|half[15:8];
    assign quarter = z8 ? half[7:0] : half[15:8];

    assign z4     = ~|quarter[7:4];
    assign eighth = z4 ? quarter[3:0] : quarter[7:4];

    // pairs, then the last single bit
    assign z2   = ~|eighth[3:2];
    assign pair = z2 ? eighth[1:0] : eighth[3:2];
    assign z1   = ~pair[1];

    assign all_zero = ~|data;

    // each level contributes one bit of the count
    always_comb begin
        if (all_zero) begin
            count = 6'd32;
        end else begin
            count = {1'b0, z16, z8, z4, z2, z1};
        end
    end

endmodule

`default_nettype wire

// File: rtl/srt_iter_core.sv
// Radix-2 SRT unsigned divide core
`default_nettype none

module srt_iter_core (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     start,
    input  wire div_types_pkg::core_cmd_t cmd,
    output logic                          done,
    output div_types_pkg::core_res_t      res
);

    srt_state_pkg::core_state_e state;

    // partial remainder and divisor, one sign bit on top
    logic [div_types_pkg::DATA_W:0] s_reg;
    logic [div_types_pkg::DATA_W:0] d_reg;
    logic [div_types_pkg::DATA_W:0] neg_d;
    logic [div_types_pkg::DATA_W:0] s_sum;

    // quotient digits collected as two bit vectors
    logic [div_types_pkg::DATA_W-1:0] pos_q;
    logic [div_types_pkg::DATA_W-1:0] neg_q;

    logic [div_types_pkg::CNT_W-1:0] counter;
    logic [div_types_pkg::CNT_W-1:0] rounds;
    logic [div_types_pkg::CNT_W-1:0] shift;

    logic [div_types_pkg::CNT_W-1:0] s_zero;
    logic [div_types_pkg::CNT_W-1:0] d_zero;

    logic [div_types_pkg::DATA_W-1:0] norm_s;
    logic [div_types_pkg::DATA_W-1:0] norm_d;
    logic [div_types_pkg::DATA_W-1:0] rem_fix;

    srt_state_pkg::srt_digit_e digit;

    leading_zero_counter u_lzc_s (
        .data  (s_reg[div_types_pkg::DATA_W-1:0]),
        .count (s_zero)
    );

    leading_zero_counter u_lzc_d (
        .data  (d_reg[div_types_pkg::DATA_W-1:0]),
        .count (d_zero)
    );

    assign norm_s = s_reg[div_types_pkg::DATA_W-1:0] << s_zero;
    assign norm_d = d_reg[div_types_pkg::DATA_W-1:0] << d_zero;
    assign neg_d  = ~d_reg + 1'b1;

    // digit from the top two bits of the partial remainder
    always_comb begin
        case (s_reg[div_types_pkg::DATA_W:div_types_pkg::DATA_W-1])
            2'b01:   digit = srt_state_pkg::DIGIT_POS;
            2'b10:   digit = srt_state_pkg::DIGIT_NEG;
            default: digit = srt_state_pkg::DIGIT_ZERO;
        endcase
    end

    always_comb begin
        case (digit)
            srt_state_pkg::DIGIT_POS: s_sum = s_reg + neg_d;
            srt_state_pkg::DIGIT_NEG: s_sum = s_reg + d_reg;
            default:                  s_sum = s_reg;
        endcase
    end

    // a negative final remainder gets the divisor added back
    // the sum is below the divisor, so 32 bits hold it
    assign rem_fix = s_reg[div_types_pkg::DATA_W]
                   ? s_reg[div_types_pkg::DATA_W-1:0] + d_reg[div_types_pkg::DATA_W-1:0]
                   : s_reg[div_types_pkg::DATA_W-1:0];

    // state and done
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= srt_state_pkg::IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                srt_state_pkg::IDLE: begin
                    if (start) begin
                        state <= srt_state_pkg::NORMALIZE;
                    end
                end
                srt_state_pkg::NORMALIZE: begin
                    if (d_zero == 6'd32 || d_zero < s_zero) begin
                        done  <= 1'b1;
                        state <= srt_state_pkg::IDLE;
                    end else begin
                        state <= srt_state_pkg::ITERATE;
                    end
                end
                srt_state_pkg::ITERATE: begin
                    if (counter == rounds) begin
                        state <= srt_state_pkg::CORRECT;
                    end
                end
                srt_state_pkg::CORRECT: begin
                    done  <= 1'b1;
                    state <= srt_state_pkg::IDLE;
                end
                default: state <= srt_state_pkg::IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            srt_state_pkg::IDLE: begin
                if (start) begin
                    s_reg <= {1'b0, cmd.dividend};
                    d_reg <= {1'b0, cmd.divisor};
                    pos_q <= '0;
                    neg_q <= '0;
                end
            end
            srt_state_pkg::NORMALIZE: begin
                if (d_zero == 6'd32) begin
                    res.quotient  <= '1;
                    res.remainder <= s_reg[div_types_pkg::DATA_W-1:0];
                    res.div_zero  <= 1'b1;
                end else if (d_zero < s_zero) begin
                    // divisor longer than dividend
                    res.quotient  <= '0;
                    res.remainder <= s_reg[div_types_pkg::DATA_W-1:0];
                    res.div_zero  <= 1'b0;
                end else begin
                    s_reg   <= {1'b0, norm_s};
                    d_reg   <= {1'b0, norm_d};
                    counter <= '0;
                    rounds  <= d_zero - s_zero;
                    shift   <= d_zero;
                end
            end
            srt_state_pkg::ITERATE: begin
                pos_q <= {pos_q[div_types_pkg::DATA_W-2:0], digit == srt_state_pkg::DIGIT_POS};
                neg_q <= {neg_q[div_types_pkg::DATA_W-2:0], digit == srt_state_pkg::DIGIT_NEG};
                // last digit leaves the remainder unshifted
                if (counter == rounds) begin
                    s_reg <= s_sum;
                end else begin
                    s_reg   <= s_sum << 1;
                    counter <= counter + 1'b1;
                end
            end
            srt_state_pkg::CORRECT: begin
                res.quotient  <= pos_q - neg_q
                               - {{(div_types_pkg::DATA_W-1){1'b0}}, s_reg[div_types_pkg::DATA_W]};
                res.remainder <= rem_fix >> shift;
                res.div_zero  <= 1'b0;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/div_control.sv
// Divider handshake and sign control
`default_nettype none

module div_control (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     req,
    input  wire div_types_pkg::div_req_t  req_data,
    output logic                          ack,
    output div_types_pkg::div_rsp_t       rsp,
    output logic                          start,
    output div_types_pkg::core_cmd_t      cmd,
    input  wire logic                     done,
    input  wire div_types_pkg::core_res_t res
);

    srt_state_pkg::ctrl_state_e state;

    // request fields kept for the fix-up
    div_types_pkg::div_op_e op_q;
    logic                   is_signed_q;
    logic                   dvd_sign;
    logic                   dvs_sign;

    logic req_dvd_neg;
    logic req_dvs_neg;

    logic [div_types_pkg::DATA_W-1:0] abs_dividend;
    logic [div_types_pkg::DATA_W-1:0] abs_divisor;

    logic                             neg_quot;
    logic                             neg_rem;
    logic [div_types_pkg::DATA_W-1:0] quot_fixed;
    logic [div_types_pkg::DATA_W-1:0] rem_fixed;

    // magnitudes of the incoming operands
    assign req_dvd_neg  = req_data.is_signed & req_data.dividend[div_types_pkg::DATA_W-1];
    assign req_dvs_neg  = req_data.is_signed & req_data.divisor[div_types_pkg::DATA_W-1];
    assign abs_dividend = req_dvd_neg ? -req_data.dividend : req_data.dividend;
    assign abs_divisor  = req_dvs_neg ? -req_data.divisor : req_data.divisor;

    // quotient sign from both operands, remainder follows the dividend
    // all-ones quotient of a zero divide keeps its value
    assign neg_quot = is_signed_q & (dvd_sign ^ dvs_sign) & ~res.div_zero;
    assign neg_rem  = is_signed_q & dvd_sign;

    assign quot_fixed = neg_quot ? -res.quotient : res.quotient;
    assign rem_fixed  = neg_rem ? -res.remainder : res.remainder;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= srt_state_pkg::WAIT_REQ;
            ack   <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                srt_state_pkg::WAIT_REQ: begin
                    if (req) begin
                        start <= 1'b1;
                        state <= srt_state_pkg::RUN;
                    end
                end
                srt_state_pkg::RUN: begin
                    if (done) begin
                        ack   <= 1'b1;
                        state <= srt_state_pkg::HOLD_ACK;
                    end
                end
                srt_state_pkg::HOLD_ACK: begin
                    // held until the requester lets go
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= srt_state_pkg::WAIT_REQ;
                    end
                end
                default: state <= srt_state_pkg::WAIT_REQ;
            endcase
        end
    end

    // request capture
    always_ff @(posedge clk) begin
        if (state == srt_state_pkg::WAIT_REQ && req) begin
            op_q         <= req_data.op;
            is_signed_q  <= req_data.is_signed;
            dvd_sign     <= req_data.dividend[div_types_pkg::DATA_W-1];
            dvs_sign     <= req_data.divisor[div_types_pkg::DATA_W-1];
            cmd.dividend <= abs_dividend;
            cmd.divisor  <= abs_divisor;
        end
    end

    // response capture
    always_ff @(posedge clk) begin
        if (state == srt_state_pkg::RUN && done) begin
            if (op_q == div_types_pkg::OP_QUOT) begin
                rsp.result <= quot_fixed;
            end else begin
                rsp.result <= rem_fixed;
            end
            rsp.div_zero <= res.div_zero;
        end
    end

endmodule

`default_nettype wire

// File: rtl/srt_div_top.sv
// SRT divider top level
`default_nettype none

module srt_div_top (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    req,
    input  wire div_types_pkg::div_req_t req_data,
    output logic                         ack,
    output div_types_pkg::div_rsp_t      rsp
);

    // control to core
    logic                     start;
    div_types_pkg::core_cmd_t cmd;

    // core to control
    logic                     done;
    div_types_pkg::core_res_t res;

    div_control u_control (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp),
        .start    (start),
        .cmd      (cmd),
        .done     (done),
        .res      (res)
    );

    srt_iter_core u_core (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .cmd   (cmd),
        .done  (done),
        .res   (res)
    );

endmodule

`default_nettype wire

// File: sim/srt_div_chk.sv
// Divider handshake assertions
`default_nettype none

module srt_div_chk (
    input wire logic                    clk,
    input wire logic                    reset,
    input wire logic                    req,
    input wire logic                    ack,
    input wire div_types_pkg::div_rsp_t rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench at the end of the run
    int failures = 0;

    // ack may only answer a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req))
        else begin
            $error("ack rose without a request");
            failures++;
        end

    rsp_held: assert property (@(posedge clk) disable iff (reset)
        (ack && $past(ack)) |-> $stable(rsp))
        else begin
            $error("rsp changed while ack was high");
            failures++;
        end

    ack_release: assert property (@(posedge clk) disable iff (reset)
        $fell(req) |-> ##[0:2] !ack)
        else begin
            $error("ack stayed high after req fell");
            failures++;
        end

    // no disable here, this one is about reset itself
    ack_after_reset: assert property (@(posedge clk) reset |=> !ack)
        else begin
            $error("ack high right after reset");
            failures++;
        end

endmodule

`default_nettype wire

// File: sim/srt_div_monitor.sv
// Divider response monitor
`default_nettype none

module srt_div_monitor #(
    parameter int NAME_W = 96
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    req,
    input  wire logic                    ack,
    input  wire div_types_pkg::div_rsp_t rsp,
    input  wire logic [NAME_W-1:0]       test_name,
    input  wire div_types_pkg::div_rsp_t exp_rsp,
    output int                           checked,
    output int                           errors
);
    timeunit 1ns;
    timeprecision 100ps;

    logic req_q;
    logic ack_q;

    // test in flight, taken when req rises
    logic [NAME_W-1:0]       name_q;
    div_types_pkg::div_rsp_t exp_q;
    div_types_pkg::div_rsp_t held_rsp;

    always @(posedge clk) begin
        if (reset) begin
            req_q   <= 1'b0;
            ack_q   <= 1'b0;
            checked <= 0;
            errors  <= 0;
        end else begin
            req_q <= req;
            ack_q <= ack;
            if (req && !req_q) begin
                name_q <= test_name;
                exp_q  <= exp_rsp;
            end
            if (ack && !ack_q) begin
                checked  <= checked + 1;
                held_rsp <= rsp;
                if (rsp !== exp_q) begin
                    errors <= errors + 1;
                    $display("ERROR %0s: expected result %h div_zero %b, actual result %h div_zero %b",
                             name_q, exp_q.result, exp_q.div_zero, rsp.result, rsp.div_zero);
                end else begin
                    $display("pass %0s: result %h div_zero %b",
                             name_q, rsp.result, rsp.div_zero);
                end
            end else if (ack && ack_q && rsp !== held_rsp) begin
                // held request must see a frozen response
                errors <= errors + 1;
                $display("test %0s: response changed while ack was still high", name_q);
            end else if (!ack && ack_q && req) begin
                // ack must stay up as long as req does
                errors <= errors + 1;
                $display("test %0s: ack dropped while req was still high", name_q);
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/srt_div_tb.sv
// SRT divider testbench
`default_nettype none

module srt_div_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NAME_W         = 96;
    localparam int NUM_DIRECTED   = 22;
    localparam int NUM_RANDOM     = 12;
    localparam int NUM_TESTS      = NUM_DIRECTED + NUM_RANDOM;
    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 50 + RESET_CYCLES;

    typedef struct packed {
        logic [NAME_W-1:0]       name;
        div_types_pkg::div_req_t req;
        logic [2:0]              hold;
        div_types_pkg::div_rsp_t exp;
    } test_row_t;

    logic                    clk;
    logic                    reset;
    logic                    req;
    div_types_pkg::div_req_t req_data;
    logic                    ack;
    div_types_pkg::div_rsp_t rsp;

    logic [NAME_W-1:0]       cur_name;
    div_types_pkg::div_rsp_t cur_exp;
    int                      checked;
    int                      mon_errors;
    int                      total_errors;

    test_row_t   rows [NUM_TESTS];
    int          row_count   = 0;
    logic [31:0] lfsr        = 32'hb9dbf5d5;
    int unsigned cycle_count = 0;

    srt_div_top UUT (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp)
    );

    srt_div_monitor #(
        .NAME_W (NAME_W)
    ) u_monitor (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .ack       (ack),
        .rsp       (rsp),
        .test_name (cur_name),
        .exp_rsp   (cur_exp),
        .checked   (checked),
        .errors    (mon_errors)
    );

    bind srt_div_top srt_div_chk u_chk (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .ack   (ack),
        .rsp   (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic        fb;
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < n; k++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    // truncating division, remainder keeps the dividend's sign
    function automatic div_types_pkg::div_rsp_t reference_rsp(
        input div_types_pkg::div_req_t r
    );
        div_types_pkg::div_rsp_t exp;
        longint a;
        longint b;
        longint q;
        longint m;
        if (r.is_signed) begin
            a = $signed(r.dividend);
            b = $signed(r.divisor);
        end else begin
            a = r.dividend;
            b = r.divisor;
        end
        if (b == 0) begin
            q = 64'hffff_ffff;
            m = a;
        end else begin
            q = a / b;
            m = a % b;
        end
        exp.result   = (r.op == div_types_pkg::OP_QUOT) ? q[31:0] : m[31:0];
        exp.div_zero = (b == 0);
        return exp;
    endfunction

    task automatic add_row(input logic [NAME_W-1:0] name, input logic [31:0] dividend,
                           input logic [31:0] divisor, input logic rem_sel, input logic sgn,
                           input int hold, input logic [31:0] exp_result, input logic exp_zero);
        test_row_t row;
        row.name          = name;
        row.req.dividend  = dividend;
        row.req.divisor   = divisor;
        row.req.op        = div_types_pkg::div_op_e'(rem_sel);
        row.req.is_signed = sgn;
        row.hold          = hold[2:0];
        row.exp.result    = exp_result;
        row.exp.div_zero  = exp_zero;
        rows[row_count]   = row;
        row_count++;
    endtask

    task automatic build_table();
        div_types_pkg::div_req_t r;
        div_types_pkg::div_rsp_t e;
        logic [31:0]             a;
        logic [31:0]             b;
        logic [31:0]             shift;
        logic [31:0]             flags;
        // name, dividend, divisor, rem, signed, hold, result, div_zero
        add_row("big_div_q", 32'd7, 32'd100, 1'b0, 1'b0, 0, 32'h0, 1'b0);
        add_row("big_div_r", 32'd7, 32'd100, 1'b1, 1'b0, 0, 32'h7, 1'b0);
        add_row("div_one_q", 32'hdeadbeef, 32'd1, 1'b0, 1'b0, 0, 32'hdeadbeef, 1'b0);
        add_row("div_one_r", 32'hdeadbeef, 32'd1, 1'b1, 1'b0, 0, 32'h0, 1'b0);
        add_row("equal_q", 32'h12345678, 32'h12345678, 1'b0, 1'b0, 0, 32'h1, 1'b0);
        add_row("full_q", 32'hffffffff, 32'd3, 1'b0, 1'b0, 0, 32'h55555555, 1'b0);
        add_row("full_r", 32'hffffffff, 32'd10, 1'b1, 1'b0, 0, 32'h5, 1'b0);
        add_row("pos_pos_q", 32'd100, 32'd7, 1'b0, 1'b1, 5, 32'he, 1'b0);
        add_row("pos_pos_r", 32'd100, 32'd7, 1'b1, 1'b1, 0, 32'h2, 1'b0);
        add_row("neg_pos_q", 32'hffffff9c, 32'd7, 1'b0, 1'b1, 0, 32'hfffffff2, 1'b0);
        add_row("neg_pos_r", 32'hffffff9c, 32'd7, 1'b1, 1'b1, 0, 32'hfffffffe, 1'b0);
        add_row("pos_neg_q", 32'd100, 32'hfffffff9, 1'b0, 1'b1, 0, 32'hfffffff2, 1'b0);
        add_row("pos_neg_r", 32'd100, 32'hfffffff9, 1'b1, 1'b1, 0, 32'h2, 1'b0);
        add_row("neg_neg_q", 32'hffffff9c, 32'hfffffff9, 1'b0, 1'b1, 0, 32'he, 1'b0);
        add_row("neg_neg_r", 32'hffffff9c, 32'hfffffff9, 1'b1, 1'b1, 2, 32'hfffffffe, 1'b0);
        add_row("zero_u_q", 32'h1234, 32'h0, 1'b0, 1'b0, 3, 32'hffffffff, 1'b1);
        add_row("zero_u_r", 32'h1234, 32'h0, 1'b1, 1'b0, 0, 32'h1234, 1'b1);
        add_row("zero_s_q", 32'hffffff9c, 32'h0, 1'b0, 1'b1, 0, 32'hffffffff, 1'b1);
        add_row("zero_s_r", 32'hffffff9c, 32'h0, 1'b1, 1'b1, 0, 32'hffffff9c, 1'b1);
        add_row("min_neg1_q", 32'h80000000, 32'hffffffff, 1'b0, 1'b1, 0, 32'h80000000, 1'b0);
        add_row("min_neg1_r", 32'h80000000, 32'hffffffff, 1'b1, 1'b1, 0, 32'h0, 1'b0);
        add_row("min_u_q", 32'h80000000, 32'hffffffff, 1'b0, 1'b0, 0, 32'h0, 1'b0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a     = random_bits(32);
            b     = random_bits(32);
            shift = random_bits(5);
            flags = random_bits(5);
            // shorter divisors give longer SRT loops
            r.dividend  = a;
            r.divisor   = b >> shift[4:0];
            r.op        = div_types_pkg::div_op_e'(flags[0]);
            r.is_signed = flags[1];
            e           = reference_rsp(r);
            add_row({"random_", 8'h61 + 8'(i)}, r.dividend, r.divisor, flags[0], flags[1],
                    int'(flags[4:2]), e.result, e.div_zero);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: ack never came for test %0s", cur_name);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        reset    = 1'b1;
        req      = 1'b0;
        req_data = '0;
        cur_name = '0;
        cur_exp  = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            @(posedge clk);
            #1;
            cur_name = rows[i].name;
            cur_exp  = rows[i].exp;
            req_data = rows[i].req;
            req      = 1'b1;
            while (!ack) begin
                @(posedge clk);
                #1;
            end
            repeat (rows[i].hold) begin
                @(posedge clk);
                #1;
            end
            req = 1'b0;
            while (ack) begin
                @(posedge clk);
                #1;
            end
        end
        repeat (2) @(posedge clk);
        total_errors = mon_errors + UUT.u_chk.failures;
        if (checked != NUM_TESTS) begin
            $display("only %0d of %0d tests got a response", checked, NUM_TESTS);
            total_errors++;
        end
        $display("%0d of %0d tests checked, %0d errors", checked, NUM_TESTS, total_errors);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: srt_div.f
rtl/div_types_pkg.sv
rtl/srt_state_pkg.sv
rtl/leading_zero_counter.sv
rtl/srt_iter_core.sv
rtl/div_control.sv
rtl/srt_div_top.sv
sim/srt_div_chk.sv
sim/srt_div_monitor.sv
sim/srt_div_tb.sv
